//--- common/mem_pkg.sv
// Data-memory package with shared widths, word and address types, request structs
package mem_pkg;

    // ------------------------------
    // Widths and sizes
    // ------------------------------

    // Data word
    localparam int WORD_WIDTH = 32;

    // Word address, covers RAM and the I/O window
    localparam int ADDR_WIDTH = 10;

    // I/O ports in the window
    localparam int IO_PORT_COUNT = 4;

    // Low address bits that pick a port after translation
    localparam int IO_PORT_ADDR_WIDTH = 2;

    // ------------------------------
    // Basic types
    // ------------------------------

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // One word per port, port 0 in the low word
    typedef word_t [IO_PORT_COUNT-1:0] io_words_t;

    // One strobe bit per port
    typedef logic [IO_PORT_COUNT-1:0] io_enables_t;

    // ------------------------------
    // Requests
    // ------------------------------

    // Raw request from the processor, one read and one write per cycle
    typedef struct packed {
        logic  read_enable;
        addr_t read_addr;
        logic  write_enable;
        addr_t write_addr;
        word_t write_data;
    } mem_req_t;

    // Registered request with I/O window flags
    typedef struct packed {
        logic  read_enable;
        addr_t read_addr;
        logic  read_is_io;
        logic  write_enable;
        addr_t write_addr;
        word_t write_data;
        logic  write_is_io;
    } mem_op_t;

endpackage

//--- design/memory/ram_sdp.sv
// Simple dual-port RAM with one synchronous write port and one registered read port
module ram_sdp #(
    parameter int depth = 1020
) (
    input  logic           clock,

    // Write port
    input  logic           wren,
    input  mem_pkg::addr_t write_addr,
    input  mem_pkg::word_t write_data,

    // Read port
    input  logic           rden,
    input  mem_pkg::addr_t read_addr,
    output mem_pkg::word_t rdata
);

    // ------------------------------
    // Storage
    // ------------------------------

    // Contents are undefined until written
    mem_pkg::word_t ram [depth];

    // ------------------------------
    // Write port
    // ------------------------------

    // Commit on the edge, only while enabled
    always_ff @(posedge clock) begin
        if (wren) begin
            ram[write_addr] <= write_data;
        end
    end

    // ------------------------------
    // Read port
    // ------------------------------

    // Output register holds its word while rden is low
    // Same-address read during a write sees the old word,
    // since both ports use nonblocking updates on one edge
    always_ff @(posedge clock) begin
        if (rden) begin
            rdata <= ram[read_addr];
        end
    end

endmodule

//--- design/memory/io_write_ports.sv
// I/O write port bank that decodes the port, updates its output word and strobes io_wren
module io_write_ports #(
    parameter int io_port_base_addr = 1020
) (
    input  logic                  clock,
    input  logic                  rst_n,

    // Registered write, already qualified as an I/O access
    input  logic                  write_enable,
    input  mem_pkg::addr_t        write_addr,
    input  mem_pkg::word_t        write_data,

    // Port side
    output mem_pkg::io_enables_t  io_wren,
    output mem_pkg::io_words_t    io_write_data
);

    // ------------------------------
    // Port decode
    // ------------------------------

    // Address relative to the start of the I/O window
    mem_pkg::addr_t port_offset;

    // Port number taken from the low offset bits
    logic [mem_pkg::IO_PORT_ADDR_WIDTH-1:0] port_sel;

    // One-hot strobe for this cycle
    mem_pkg::io_enables_t port_wren;

    assign port_offset = write_addr - mem_pkg::addr_t'(io_port_base_addr);
    assign port_sel    = port_offset[mem_pkg::IO_PORT_ADDR_WIDTH-1:0];

    // All zero when no I/O write is pending
    always_comb begin
        port_wren           = '0;
        port_wren[port_sel] = write_enable;
    end

    // ------------------------------
    // Output registers
    // ------------------------------

    // Only the addressed word changes
    // io_wren follows the same edge, so it lines up with the new word
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            io_wren       <= '0;
            io_write_data <= '0;
        end else begin
            io_wren <= port_wren;
            for (int i = 0; i < mem_pkg::IO_PORT_COUNT; i++) begin
                if (port_wren[i]) begin
                    io_write_data[i] <= write_data;
                end
            end
        end
    end

endmodule

//--- design/memory/memory.sv
// Memory block with two-stage read and write pipelines steering between RAM and I/O ports
module memory #(
    parameter int mem_depth         = 1020,
    parameter int io_port_base_addr = 1020
) (
    input  logic                  clock,
    input  logic                  rst_n,

    // Decoded request from the request stage
    input  mem_pkg::mem_op_t      op,

    // I/O input words, sampled in read stage one
    input  mem_pkg::io_words_t    io_read_data,

    output mem_pkg::word_t        read_data,
    output mem_pkg::io_enables_t  io_wren,
    output mem_pkg::io_words_t    io_write_data
);

    // ------------------------------
    // Read stage one
    // ------------------------------

    // RAM read only for enabled reads outside the I/O window
    logic           ram_rden;
    mem_pkg::word_t ram_rdata;

    assign ram_rden = op.read_enable & ~op.read_is_io;

    // Translate the read address into a port number
    mem_pkg::addr_t                         io_read_offset;
    logic [mem_pkg::IO_PORT_ADDR_WIDTH-1:0] io_read_sel;

    assign io_read_offset = op.read_addr - mem_pkg::addr_t'(io_port_base_addr);
    assign io_read_sel    = io_read_offset[mem_pkg::IO_PORT_ADDR_WIDTH-1:0];

    // Captured I/O word, aligned with the RAM output register
    mem_pkg::word_t io_read_word_q;

    always_ff @(posedge clock) begin
        io_read_word_q <= io_read_data[io_read_sel];
    end

    // Read control carried into stage two
    logic read_enable_q;
    logic read_is_io_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            read_enable_q <= 1'b0;
            read_is_io_q  <= 1'b0;
        end else begin
            read_enable_q <= op.read_enable;
            read_is_io_q  <= op.read_is_io;
        end
    end

    // ------------------------------
    // Read stage two
    // ------------------------------

    // Pick the source, then annul when no read was issued
    // Does not rely on what the RAM holds while rden is low
    mem_pkg::word_t read_data_next;

    always_comb begin
        if (!read_enable_q) begin
            read_data_next = '0;
        end else if (read_is_io_q) begin
            read_data_next = io_read_word_q;
        end else begin
            read_data_next = ram_rdata;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            read_data <= '0;
        end else begin
            read_data <= read_data_next;
        end
    end

    // ------------------------------
    // Write stage one
    // ------------------------------

    // Split the write enable by target
    logic           ram_wren_q;
    logic           io_write_enable_q;
    mem_pkg::addr_t write_addr_q;
    mem_pkg::word_t write_data_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ram_wren_q        <= 1'b0;
            io_write_enable_q <= 1'b0;
        end else begin
            ram_wren_q        <= op.write_enable & ~op.write_is_io;
            io_write_enable_q <= op.write_enable & op.write_is_io;
        end
    end

    // Write payload, meaningful only with an enable above
    always_ff @(posedge clock) begin
        write_addr_q <= op.write_addr;
        write_data_q <= op.write_data;
    end

    // ------------------------------
    // Write stage two and storage
    // ------------------------------

    // RAM commits on the stage two edge
    // Its read port is stage one of the read pipeline
    ram_sdp #(
        .depth      (mem_depth)
    ) ram_i (
        .clock      (clock),
        .wren       (ram_wren_q),
        .write_addr (write_addr_q),
        .write_data (write_data_q),
        .rden       (ram_rden),
        .read_addr  (op.read_addr),
        .rdata      (ram_rdata)
    );

    // I/O output registers update on the same edge as the RAM
    io_write_ports #(
        .io_port_base_addr (io_port_base_addr)
    ) io_write_ports_i (
        .clock             (clock),
        .rst_n             (rst_n),
        .write_enable      (io_write_enable_q),
        .write_addr        (write_addr_q),
        .write_data        (write_data_q),
        .io_wren           (io_wren),
        .io_write_data     (io_write_data)
    );

    // ------------------------------
    // Checks
    // ------------------------------

    // Never more than one I/O strobe at a time
    a_io_wren_onehot : assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0(io_wren));

    // Flags from the request stage keep RAM traffic inside the array
    a_ram_read_in_range : assert property (@(posedge clock) disable iff (!rst_n)
        (op.read_enable && !op.read_is_io) |-> (int'(op.read_addr) < mem_depth));

    a_ram_write_in_range : assert property (@(posedge clock) disable iff (!rst_n)
        (op.write_enable && !op.write_is_io) |-> (int'(op.write_addr) < mem_depth));

endmodule

//--- design/mem_request_stage.sv
// Request stage that registers memory requests and flags I/O-window addresses
module mem_request_stage #(
    parameter int io_port_base_addr = 1020
) (
    input  logic              clock,
    input  logic              rst_n,
    input  mem_pkg::mem_req_t req,
    output mem_pkg::mem_op_t  op
);

    // ------------------------------
    // I/O window decode
    // ------------------------------

    // True when an address falls in the I/O port words
    function automatic logic in_io_window(input mem_pkg::addr_t addr);
        return (int'(addr) >= io_port_base_addr) &&
               (int'(addr) < io_port_base_addr + mem_pkg::IO_PORT_COUNT);
    endfunction

    // ------------------------------
    // Request registers
    // ------------------------------

    // Enables, cleared by reset
    logic read_enable_q;
    logic write_enable_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            read_enable_q  <= 1'b0;
            write_enable_q <= 1'b0;
        end else begin
            read_enable_q  <= req.read_enable;
            write_enable_q <= req.write_enable;
        end
    end

    // Addresses, data and window flags
    mem_pkg::addr_t read_addr_q;
    mem_pkg::addr_t write_addr_q;
    mem_pkg::word_t write_data_q;
    logic           read_is_io_q;
    logic           write_is_io_q;

    always_ff @(posedge clock) begin
        read_addr_q   <= req.read_addr;
        write_addr_q  <= req.write_addr;
        write_data_q  <= req.write_data;
        read_is_io_q  <= in_io_window(req.read_addr);
        write_is_io_q <= in_io_window(req.write_addr);
    end

    // Flags arrive together with their addresses
    assign op = '{
        read_enable  : read_enable_q,
        read_addr    : read_addr_q,
        read_is_io   : read_is_io_q,
        write_enable : write_enable_q,
        write_addr   : write_addr_q,
        write_data   : write_data_q,
        write_is_io  : write_is_io_q
    };

endmodule

//--- design/mem_subsystem.sv
// Data-memory subsystem top joining the request stage and the memory block
module mem_subsystem #(
    parameter int mem_depth         = 1020,
    parameter int io_port_base_addr = 1020
) (
    input  logic                  clock,
    input  logic                  rst_n,

    // Processor side
    input  mem_pkg::mem_req_t     req,
    output mem_pkg::word_t        read_data,

    // I/O port side
    input  mem_pkg::io_words_t    io_read_data,
    output mem_pkg::io_enables_t  io_wren,
    output mem_pkg::io_words_t    io_write_data
);

    // Registered request with window flags
    mem_pkg::mem_op_t op;

    // ------------------------------
    // Decode stage
    // ------------------------------

    mem_request_stage #(
        .io_port_base_addr (io_port_base_addr)
    ) mem_request_stage_i (
        .clock             (clock),
        .rst_n             (rst_n),
        .req               (req),
        .op                (op)
    );

    // ------------------------------
    // RAM and I/O ports
    // ------------------------------

    memory #(
        .mem_depth         (mem_depth),
        .io_port_base_addr (io_port_base_addr)
    ) memory_i (
        .clock             (clock),
        .rst_n             (rst_n),
        .op                (op),
        .io_read_data      (io_read_data),
        .read_data         (read_data),
        .io_wren           (io_wren),
        .io_write_data     (io_write_data)
    );

endmodule

//--- tests/tb_mem_subsystem.sv
// Testbench for the data-memory subsystem, random traffic checked against a reference model
module tb_mem_subsystem;

    // ------------------------------
    // Configuration
    // ------------------------------

    localparam int mem_depth         = 1020;
    localparam int io_base           = 1020;
    localparam int num_cycles        = 4000;
    localparam int total_cycles      = num_cycles + 4;
    localparam int reset_timeout     = 50;

    // Traffic phases, in issue cycles
    localparam int ram_phase_end     = 800;
    localparam int no_read_phase_end = 1200;
    localparam int io_phase_end      = 2000;

    // ------------------------------
    // DUT signals
    // ------------------------------

    logic                 clock = 1'b0;
    logic                 rst_n;
    mem_pkg::mem_req_t    req;
    mem_pkg::io_words_t   io_read_data;
    mem_pkg::word_t       read_data;
    mem_pkg::io_enables_t io_wren;
    mem_pkg::io_words_t   io_write_data;

    always #4 clock = ~clock;

    mem_subsystem #(
        .mem_depth         (mem_depth),
        .io_port_base_addr (io_base)
    ) dut_i (
        .clock             (clock),
        .rst_n             (rst_n),
        .req               (req),
        .io_read_data      (io_read_data),
        .read_data         (read_data),
        .io_wren           (io_wren),
        .io_write_data     (io_write_data)
    );

    // Reset held for 10 cycles
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clock);
        rst_n <= 1'b1;
    end

    // ------------------------------
    // Reference model state
    // ------------------------------

    integer               seed = 74189;
    // Only written RAM words have entries
    mem_pkg::word_t       ram_model [int];
    mem_pkg::io_words_t   io_out_model;
    mem_pkg::io_enables_t exp_wren;
    // Requests and I/O inputs as driven, by cycle
    mem_pkg::mem_req_t    req_hist [total_cycles];
    mem_pkg::io_words_t   io_hist [total_cycles];
    // Expected read_data, one entry per cycle
    mem_pkg::word_t       exp_read_q [$];
    bit                   exp_known_q [$];
    int                   check_count;
    int                   error_count;
    int                   skipped_reads;

    function automatic int rand_below(input int limit);
        return int'($unsigned($random(seed)) % limit);
    endfunction

    // I/O window is IO_PORT_COUNT words from the base address
    function automatic bit is_io_addr(input mem_pkg::addr_t addr);
        return (int'(addr) >= io_base) && (int'(addr) < io_base + mem_pkg::IO_PORT_COUNT);
    endfunction

    // Narrow range gives frequent hits on written words
    function automatic mem_pkg::addr_t pick_addr(input bit want_io, input bit narrow);
        if (want_io) begin
            return mem_pkg::addr_t'(io_base + rand_below(mem_pkg::IO_PORT_COUNT));
        end else if (narrow) begin
            return mem_pkg::addr_t'(rand_below(16));
        end
        return mem_pkg::addr_t'(rand_below(mem_depth));
    endfunction

    function automatic mem_pkg::mem_req_t make_request(input int k);
        mem_pkg::mem_req_t r;
        bit                read_io;
        bit                write_io;
        bit                narrow;
        bit                no_reads;
        r = '0;
        if (k >= num_cycles) begin
            return r;
        end
        read_io  = 1'b0;
        write_io = 1'b0;
        narrow   = 1'b1;
        no_reads = (k >= ram_phase_end) && (k < no_read_phase_end);
        if (k >= io_phase_end) begin
            // Mixed traffic over both ranges
            read_io  = (rand_below(6) == 0);
            write_io = (rand_below(6) == 0);
            narrow   = (rand_below(2) == 0);
        end else if (k >= no_read_phase_end) begin
            read_io  = rand_below(2);
            write_io = rand_below(2);
        end
        r.read_enable  = no_reads ? 1'b0 : (rand_below(4) != 0);
        r.read_addr    = pick_addr(read_io, narrow);
        if (no_reads) begin
            r.read_addr = mem_pkg::addr_t'(rand_below(1 << mem_pkg::ADDR_WIDTH));
        end
        r.write_enable = (rand_below(2) == 0);
        r.write_addr   = pick_addr(write_io, narrow);
        r.write_data   = $random(seed);
        // Same address for read and write in one cycle
        if ((rand_below(4) == 0) && (read_io == write_io) && !no_reads) begin
            r.read_addr = r.write_addr;
        end
        return r;
    endfunction

    // Idle before the first traffic cycle
    function automatic mem_pkg::mem_req_t req_at(input int n);
        if (n < 0) begin
            return '0;
        end
        return req_hist[n];
    endfunction

    function automatic mem_pkg::io_words_t io_at(input int n);
        if (n < 0) begin
            return '0;
        end
        return io_hist[n];
    endfunction

    // ------------------------------
    // Model steps at edge k
    // ------------------------------

    // Read driven at k-2 sees state before commits at k, I/O input driven at k-1
    task automatic evaluate_read(input int k);
        mem_pkg::mem_req_t  r;
        mem_pkg::io_words_t io_now;
        int                 addr;
        r      = req_at(k - 2);
        io_now = io_at(k - 1);
        addr   = int'(r.read_addr);
        if (!r.read_enable) begin
            exp_read_q.push_back('0);
            exp_known_q.push_back(1'b1);
        end else if (is_io_addr(r.read_addr)) begin
            exp_read_q.push_back(io_now[addr - io_base]);
            exp_known_q.push_back(1'b1);
        end else if (ram_model.exists(addr)) begin
            exp_read_q.push_back(ram_model[addr]);
            exp_known_q.push_back(1'b1);
        end else begin
            // Unwritten RAM word
            exp_read_q.push_back('0);
            exp_known_q.push_back(1'b0);
        end
    endtask

    // Write driven at k-3 commits at edge k
    task automatic commit_write(input int k);
        mem_pkg::mem_req_t r;
        int                port;
        r        = req_at(k - 3);
        exp_wren = '0;
        if (r.write_enable) begin
            if (is_io_addr(r.write_addr)) begin
                port               = int'(r.write_addr) - io_base;
                io_out_model[port] = r.write_data;
                exp_wren[port]     = 1'b1;
            end else begin
                ram_model[int'(r.write_addr)] = r.write_data;
            end
        end
    endtask

    // ------------------------------
    // Checking
    // ------------------------------

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic check_outputs(input int k);
        mem_pkg::word_t exp_word;
        bit             known;
        exp_word = exp_read_q.pop_front();
        known    = exp_known_q.pop_front();
        if (known) begin
            check_value(read_data, exp_word, $sformatf("read_data in cycle %0d", k));
        end else begin
            skipped_reads++;
        end
        check_value(io_wren, exp_wren, $sformatf("io_wren in cycle %0d", k));
        check_value(io_write_data, io_out_model, $sformatf("io_write_data in cycle %0d", k));
    endtask

    task automatic wait_reset_release(output bit timed_out);
        int cycles;
        cycles    = 0;
        timed_out = 1'b0;
        while ((rst_n !== 1'b1) && !timed_out) begin
            @(posedge clock);
            cycles++;
            if (cycles >= reset_timeout) begin
                timed_out = 1'b1;
            end
        end
    endtask

    // Drive at the rising edge, check at the falling edge
    task automatic run_traffic();
        mem_pkg::mem_req_t  next_req;
        mem_pkg::io_words_t next_io;
        // read_data right after the first edge comes from idle stages
        exp_read_q.push_back('0);
        exp_known_q.push_back(1'b1);
        for (int k = 0; k < total_cycles; k++) begin
            @(posedge clock);
            evaluate_read(k);
            commit_write(k);
            next_req     = make_request(k);
            next_io      = {$random(seed), $random(seed), $random(seed), $random(seed)};
            req_hist[k]  = next_req;
            io_hist[k]   = next_io;
            req          <= next_req;
            io_read_data <= next_io;
            @(negedge clock);
            check_outputs(k);
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        bit timed_out;
        req           = '0;
        io_read_data  = '0;
        io_out_model  = '0;
        exp_wren      = '0;
        check_count   = 0;
        error_count   = 0;
        skipped_reads = 0;
        wait_reset_release(timed_out);
        if (timed_out) begin
            $display("Timeout: reset was not released within %0d cycles", reset_timeout);
            $display("tests failed");
            $finish;
        end else begin
            // Reset values
            @(negedge clock);
            check_value(read_data, '0, "read_data after reset");
            check_value(io_wren, '0, "io_wren after reset");
            check_value(io_write_data, '0, "io_write_data after reset");
            run_traffic();
            $display("Summary: %0d checks, %0d errors, %0d unwritten RAM reads skipped",
                     check_count, error_count, skipped_reads);
            if (error_count == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

//--- tb.f
common/mem_pkg.sv
design/memory/ram_sdp.sv
design/memory/io_write_ports.sv
design/memory/memory.sv
design/mem_request_stage.sv
design/mem_subsystem.sv
tests/tb_mem_subsystem.sv
